// File: flowMux.f
hdl/flowMuxPkg.sv
hdl/flowSkidBuffer.sv
hdl/roundRobinArbiter.sv
hdl/flowMuxCore.sv
hdl/flowMux.sv
testbench/flowMuxTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the flowMux testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module flowMuxTb \
  -f flowMux.f \
  -o flowMuxSim

# The verdict comes from the testbench output
simOutput=$(./obj_dir/flowMuxSim 2>&1) || true
echo "$simOutput"
if echo "$simOutput" | grep -qx "Finished with no errors"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: testbench/flowMuxInput.txt
// One item per line, five hex digits: phase, flow, data (two digits), popReady bit
// Phase 1 latency, 2 rotation, 3 stall then popReady pattern, 4 random stalls unless bit is 1
10a51
113c1
127e1
13011
20101
21201
22301
23401
20111
21211
22311
23411
30500
31601
32701
33800
30511
31610
32710
33811
30521
31621
32720
33821
42c10
40c20
42c31
43c40
41c50
40c61
43c70
41c80

// File: testbench/flowMuxTb.sv
`timescale 1ns/100ps

module flowMuxTb
  import flowMuxPkg::*;
();

  localparam int NumFlows    = DefaultNumFlows;
  localparam int DataWidth   = DefaultDataWidth;
  localparam int MaxItems    = 64;
  localparam int StallCycles = 10;

  // Phase tags of the input file
  localparam logic [3:0] PhaseLatency  = 4'd1;
  localparam logic [3:0] PhaseRotation = 4'd2;
  localparam logic [3:0] PhaseStall    = 4'd3;
  localparam logic [3:0] PhaseRandom   = 4'd4;

  logic                               clk;
  logic                               reset;
  logic [NumFlows-1:0]                pushValid;
  logic [NumFlows-1:0]                pushReady;
  logic [NumFlows-1:0][DataWidth-1:0] pushData;
  logic                               popReady;
  logic                               popValid;
  logic [DataWidth-1:0]               popData;
  flowIndex_t                         popFlow;

  // Item word is phase, flow, data and ready bit from high to low
  logic [19:0] items [MaxItems];
  int          itemCount;
  int          cycleCount = 0;
  int          cycleLimit = 1000;
  int          errorCount = 0;

  // Items still to push, then the scoreboard of accepted ones
  logic [DataWidth-1:0] pending [NumFlows][$];
  logic [DataWidth-1:0] expData [NumFlows][$];
  int                   expCycle [NumFlows][$];
  logic                 readyPattern [$];

  // Expected arbiter pointer, one above the last popped flow
  int                   rrPtr = 0;
  logic                 latencyCheck = 1'b0;
  logic                 rotationCheck = 1'b0;
  logic                 randomStalls = 1'b0;
  logic                 forceReady = 1'b0;
  logic                 stallSeen = 1'b0;
  logic [DataWidth-1:0] stallData;
  flowIndex_t           stallFlow;

  flowMux #(
    .NumFlows (NumFlows),
    .DataWidth(DataWidth)
  ) flowMux_inst (
    .clk      (clk),
    .reset    (reset),
    .pushValid(pushValid),
    .pushReady(pushReady),
    .pushData (pushData),
    .popReady (popReady),
    .popValid (popValid),
    .popData  (popData),
    .popFlow  (popFlow)
  );

  // 20 ns clock period
  always #10 clk = ~clk;

  // --------------------
  // Timeout and checks
  // --------------------

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Run stopped after %0d cycles, the DUT never drained its items", cycleCount);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0d ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
    end
  endtask

  // Sampled mid-cycle, where every DUT signal has settled
  always @(negedge clk) begin
    int f;
    if (!reset) begin
      // Push transfers move items from the producers to the scoreboard
      for (int i = 0; i < NumFlows; i++) begin
        if (pushValid[i] && pushReady[i]) begin
          expData[i].push_back(pushData[i]);
          expCycle[i].push_back(cycleCount);
          void'(pending[i].pop_front());
        end
      end
      // Stalled output has to hold
      if (stallSeen) begin
        checkValue(32'(popValid), 32'd1, "popValid dropped under stall");
        checkValue(32'(popData), 32'(stallData), "popData moved under stall");
        checkValue(32'(popFlow), 32'(stallFlow), "popFlow moved under stall");
      end
      stallSeen = popValid && !popReady;
      stallData = popData;
      stallFlow = popFlow;
      if (popValid && popReady) begin
        f = int'(popFlow);
        if (f >= NumFlows || expData[f].size() == 0) begin
          errorCount++;
          $display("Error at %0d ns: pop on flow %0d with no item pushed on it", $time, f);
        end else begin
          checkValue(32'(popData), 32'(expData[f][0]), "popData against pushed item");
          if (latencyCheck) begin
            checkValue(32'(cycleCount - expCycle[f][0]), 32'd2, "push to pop latency");
          end
          if (rotationCheck) begin
            checkValue(32'(f), 32'(rrPtr), "round-robin flow order");
          end
          void'(expData[f].pop_front());
          void'(expCycle[f].pop_front());
        end
        // Pointer moves past the winner on every transfer
        rrPtr = (f + 1) % NumFlows;
      end
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  // Producers present their oldest item, inputs change 1 ns after the edge
  task automatic stepCycle(input logic readyBit);
    @(posedge clk);
    #1;
    for (int i = 0; i < NumFlows; i++) begin
      pushValid[i] = (pending[i].size() != 0);
      pushData[i]  = (pending[i].size() != 0) ? pending[i][0] : '0;
    end
    popReady = readyBit;
  endtask

  function automatic logic nextReady(input int step);
    if (randomStalls) begin
      return forceReady || (($urandom % 3) != 0);
    end else if (readyPattern.size() == 0) begin
      return 1'b1;
    end
    return readyPattern[step % readyPattern.size()];
  endfunction

  // Runs until no item is waiting or in flight
  task automatic drainFlows();
    int   step;
    logic busy;
    step = 0;
    busy = 1'b1;
    while (busy) begin
      stepCycle(nextReady(step));
      step++;
      busy = 1'b0;
      for (int i = 0; i < NumFlows; i++) begin
        if (pending[i].size() != 0 || expData[i].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  task automatic runPhase(input logic [3:0] tag);
    int f;
    readyPattern.delete();
    for (int k = 0; k < itemCount; k++) begin
      if (items[k][19:16] == tag) begin
        f = int'(items[k][15:12]);
        pending[f].push_back(items[k][11:4]);
        readyPattern.push_back(items[k][0]);
        forceReady = items[k][0];
        // Latency items travel alone
        if (tag == PhaseLatency) begin
          drainFlows();
        end
        // Sparse pushes, each item only waits for acceptance
        while (tag == PhaseRandom && pending[f].size() != 0) begin
          stepCycle(nextReady(k));
        end
      end
    end
    // Long stall so that every buffer with work left fills to two entries
    if (tag == PhaseStall) begin
      repeat (StallCycles) stepCycle(1'b0);
      for (int i = 0; i < NumFlows; i++) begin
        if (pending[i].size() != 0) begin
          checkValue(32'(pushReady[i]), 32'd0, "pushReady high with two items buffered");
        end
      end
    end
    forceReady = 1'b0;
    drainFlows();
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    pushValid = '0;
    pushData  = '0;
    popReady  = 1'b0;
    void'($urandom(32'h493));
    for (int i = 0; i < MaxItems; i++) begin
      items[i] = '0;
    end
    $readmemh("testbench/flowMuxInput.txt", items);
    // Item list ends at the first word without a phase tag
    itemCount = 0;
    while (itemCount < MaxItems && items[itemCount][19:16] != 4'd0) begin
      itemCount++;
    end
    cycleLimit = 8 * itemCount + 200;

    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    checkValue(32'(popValid), 32'd0, "popValid after reset");
    checkValue(32'(pushReady), 32'({NumFlows{1'b1}}), "pushReady after reset");

    latencyCheck = 1'b1;
    runPhase(PhaseLatency);
    latencyCheck  = 1'b0;
    rotationCheck = 1'b1;
    runPhase(PhaseRotation);
    rotationCheck = 1'b0;
    runPhase(PhaseStall);
    randomStalls = 1'b1;
    runPhase(PhaseRandom);

    // Every pushed item came out, so nothing may be left inside the DUT
    checkValue(32'(popValid), 32'd0, "popValid after the last item");
    checkValue(32'(pushReady), 32'({NumFlows{1'b1}}), "pushReady after the last item");
    $display("Ran %0d items in %0d cycles with %0d errors", itemCount, cycleCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : flowMuxTb

// File: hdl/flowMux.sv
`timescale 1ns/100ps

module flowMux
  import flowMuxPkg::*;
#(
  parameter int NumFlows  = DefaultNumFlows,
  parameter int DataWidth = DefaultDataWidth
) (
  input  logic                               clk,
  input  logic                               reset,
  // Producer flows
  input  logic [NumFlows-1:0]                pushValid,
  output logic [NumFlows-1:0]                pushReady,
  input  logic [NumFlows-1:0][DataWidth-1:0] pushData,
  // Consumer side
  input  logic                               popReady,
  output logic                               popValid,
  output logic [DataWidth-1:0]               popData,
  output flowIndex_t                         popFlow
);

  // Flow count has to fit the index type
  if ((NumFlows < 2) || (NumFlows > MaxNumFlows)) begin : genNumFlowsCheck
    $error("flowMux: NumFlows must lie between 2 and MaxNumFlows");
  end

  // Output payload, data above the winning flow index
  typedef logic [DataWidth+FlowIndexWidth-1:0] outPayload_t;

  logic [NumFlows-1:0]                bufValid;
  logic [NumFlows-1:0]                bufReady;
  logic [NumFlows-1:0][DataWidth-1:0] bufData;

  logic                 coreValid;
  logic                 coreReady;
  logic [DataWidth-1:0] coreData;
  flowIndex_t           coreFlow;
  outPayload_t          outPayload;

  // --------------------
  // Input buffers
  // --------------------

  // One skid buffer per flow cuts the ready path back to the producer
  for (genvar i = 0; i < NumFlows; i++) begin : genInputBuffers
    flowSkidBuffer #(
      .payload_t(logic [DataWidth-1:0])
    ) inBuf_inst (
      .clk      (clk),
      .reset    (reset),
      .pushValid(pushValid[i]),
      .pushReady(pushReady[i]),
      .pushData (pushData[i]),
      .popReady (bufReady[i]),
      .popValid (bufValid[i]),
      .popData  (bufData[i])
    );
  end

  // --------------------
  // Mux core
  // --------------------

  flowMuxCore #(
    .NumFlows (NumFlows),
    .DataWidth(DataWidth)
  ) core_inst (
    .clk      (clk),
    .reset    (reset),
    .bufValid (bufValid),
    .bufReady (bufReady),
    .bufData  (bufData),
    .coreReady(coreReady),
    .coreValid(coreValid),
    .coreData (coreData),
    .coreFlow (coreFlow)
  );

  // --------------------
  // Output buffer
  // --------------------

  // Registers the unstable core output so the consumer sees steady data
  flowSkidBuffer #(
    .payload_t(outPayload_t)
  ) outBuf_inst (
    .clk      (clk),
    .reset    (reset),
    .pushValid(coreValid),
    .pushReady(coreReady),
    .pushData ({coreData, coreFlow}),
    .popReady (popReady),
    .popValid (popValid),
    .popData  (outPayload)
  );

  assign {popData, popFlow} = outPayload;

endmodule : flowMux

// File: hdl/flowMuxCore.sv
`timescale 1ns/100ps

module flowMuxCore
  import flowMuxPkg::*;
#(
  parameter int NumFlows  = DefaultNumFlows,
  parameter int DataWidth = DefaultDataWidth
) (
  input  logic                               clk,
  input  logic                               reset,
  // Input buffers
  input  logic [NumFlows-1:0]                bufValid,
  output logic [NumFlows-1:0]                bufReady,
  input  logic [NumFlows-1:0][DataWidth-1:0] bufData,
  // Toward the output buffer, zero latency so data may shift while waiting
  input  logic                               coreReady,
  output logic                               coreValid,
  output logic [DataWidth-1:0]               coreData,
  output flowIndex_t                         coreFlow
);

  // Integration check on the flow count
  if ((NumFlows < 2) || (NumFlows > MaxNumFlows)) begin : genNumFlowsCheck
    $error("flowMuxCore: NumFlows must lie between 2 and MaxNumFlows");
  end

  // --------------------
  // Arbitration
  // --------------------

  logic [NumFlows-1:0] grant;
  logic                priorityUpdate;

  // Pointer advances only on an actual pop transfer
  assign priorityUpdate = coreValid && coreReady;

  roundRobinArbiter #(
    .NumFlows(NumFlows)
  ) arbiter_inst (
    .clk           (clk),
    .reset         (reset),
    .request       (bufValid),
    .priorityUpdate(priorityUpdate),
    .grant         (grant)
  );

  // Arbiter always grants when anything is requested
  assign coreValid = |bufValid;
  assign bufReady  = grant & {NumFlows{coreReady}};

  // --------------------
  // One-hot data mux and index encode
  // --------------------

  always_comb begin
    coreData = '0;
    coreFlow = '0;
    for (int i = 0; i < NumFlows; i++) begin
      coreData = coreData | (bufData[i] & {DataWidth{grant[i]}});
      if (grant[i]) begin
        coreFlow = flowIndex_t'(i);
      end
    end
  end

  // Transferred data comes from the flow that was accepted
  for (genvar i = 0; i < NumFlows; i++) begin : genDataSelectedCheck
    dataSelected: assert property (@(posedge clk) disable iff (reset)
      (bufValid[i] && bufReady[i]) |-> ((coreData == bufData[i]) && (coreFlow == i)));
  end

endmodule : flowMuxCore

// File: hdl/roundRobinArbiter.sv
`timescale 1ns/100ps

module roundRobinArbiter
  import flowMuxPkg::*;
#(
  parameter int NumFlows = DefaultNumFlows
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [NumFlows-1:0] request,
  input  logic                priorityUpdate,
  output logic [NumFlows-1:0] grant
);

  localparam int PtrWidth = $clog2(NumFlows);

  // --------------------
  // Priority pointer
  // --------------------

  // Flow with the highest priority this cycle
  logic [PtrWidth-1:0] ptr;
  logic [PtrWidth-1:0] winIdx;
  logic [PtrWidth-1:0] nextPtr;
  logic                anyGrant;

  // Scan upward from the pointer and wrap around
  always_comb begin
    int idx;
    anyGrant = 1'b0;
    winIdx   = '0;
    for (int off = 0; off < NumFlows; off++) begin
      idx = int'(ptr) + off;
      if (idx >= NumFlows) begin
        idx = idx - NumFlows;
      end
      if (!anyGrant && request[idx]) begin
        anyGrant = 1'b1;
        winIdx   = PtrWidth'(idx);
      end
    end
  end

  assign grant = anyGrant ? (NumFlows'(1) << winIdx) : '0;

  // One above the winner, wrapping at the last flow
  assign nextPtr = (int'(winIdx) == NumFlows - 1) ? '0 : winIdx + PtrWidth'(1);

  // Pointer only moves on an accepted grant, so a waiting grant can be preempted
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr <= '0;
    end else if (priorityUpdate && anyGrant) begin
      ptr <= nextPtr;
    end
  end

  // --------------------
  // Checks
  // --------------------

  grantOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

  grantSubsetOfRequest: assert property (@(posedge clk) disable iff (reset)
    (grant & ~request) == '0);

endmodule : roundRobinArbiter

// File: hdl/flowSkidBuffer.sv
`timescale 1ns/100ps

module flowSkidBuffer
  import flowMuxPkg::*;
#(
  parameter type payload_t = logic [DefaultDataWidth-1:0]
) (
  input  logic     clk,
  input  logic     reset,
  // Push side
  input  logic     pushValid,
  output logic     pushReady,
  input  payload_t pushData,
  // Pop side
  input  logic     popReady,
  output logic     popValid,
  output payload_t popData
);

  // --------------------
  // Storage and occupancy
  // --------------------

  // Main register holds the oldest entry, skid register the second one
  payload_t   mainData;
  payload_t   skidData;
  logic [1:0] count;
  logic [1:0] countNext;

  logic pushFire;
  logic popFire;
  logic loadMainFromPush;
  logic loadMainFromSkid;
  logic loadSkid;

  assign pushFire = pushValid && pushReady;
  assign popFire  = popValid && popReady;

  // Oldest entry is always in the main register
  assign popValid = (count != 2'd0);
  assign popData  = mainData;

  always_comb begin
    case ({pushFire, popFire})
      2'b10:   countNext = count + 2'd1;
      2'b01:   countNext = count - 2'd1;
      default: countNext = count;
    endcase
  end

  // Push goes straight to main when main is empty or being drained
  assign loadMainFromPush = pushFire && ((count == 2'd0) || ((count == 2'd1) && popFire));
  // Skid entry moves up once main is popped
  assign loadMainFromSkid = popFire && (count == 2'd2);
  // Push lands in skid when main is occupied and stays put
  assign loadSkid = pushFire && (count == 2'd1) && !popFire;

  always_ff @(posedge clk) begin
    if (reset) begin
      count     <= 2'd0;
      pushReady <= 1'b1;
    end else begin
      count <= countNext;
      // Ready drops in the cycle after the second entry arrives
      pushReady <= (countNext != 2'd2);
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (loadMainFromPush) begin
      mainData <= pushData;
    end else if (loadMainFromSkid) begin
      mainData <= skidData;
    end
    if (loadSkid) begin
      skidData <= pushData;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Registered ready must never let a third entry in
  noPushWhenFull: assert property (@(posedge clk) disable iff (reset)
    (count == 2'd2) |-> !pushFire);

  // Output holds still while the consumer stalls
  popStableWhenStalled: assert property (@(posedge clk) disable iff (reset)
    (popValid && !popReady) |=> (popValid && $stable(popData)));

endmodule : flowSkidBuffer

// File: hdl/flowMuxPkg.sv
package flowMuxPkg;

  // --------------------
  // Flow indexing
  // --------------------

  // Width of a flow index, enough for up to 16 flows
  localparam int FlowIndexWidth = 4;

  // Upper limit on the number of flows
  localparam int MaxNumFlows = 16;

  // Index of one flow, also carried beside the output data
  typedef logic [FlowIndexWidth-1:0] flowIndex_t;

  // --------------------
  // Default sizes
  // --------------------

  // Number of flows when the top level is left at its defaults
  localparam int DefaultNumFlows = 4;

  // Data word width in bits
  localparam int DefaultDataWidth = 8;

endpackage : flowMuxPkg
